/* nodePkg.sv */
package nodePkg;

    // Queue sizing
    localparam int QDEPTH = 4;
    localparam int QPTRW  = $clog2(QDEPTH);
    localparam logic [QPTRW:0] QFULL = (QPTRW + 1)'(QDEPTH);
    localparam logic [QPTRW:0] QLOW  = (QPTRW + 1)'(QDEPTH - 2);  // At least two slots free

    // Packet type codes with 3'b111 reserved and dropped
    typedef enum logic [2:0] {
        PT_HEARTBEAT = 3'b000,
        PT_ELECT     = 3'b001,
        PT_INVALID   = 3'b010,
        PT_MEMBER    = 3'b011,
        PT_SLOT      = 3'b100,
        PT_DATA      = 3'b101,
        PT_SOS       = 3'b110
    } pktType_e;

    typedef logic [15:0] nodeId_t;

    typedef struct packed {
        logic [7:0] seq;
        logic [7:0] value;
    } dataField_s;

    typedef struct packed {
        logic [7:0] rank;
        logic [7:0] slot;
    } ctrlField_s;

    // One payload word read through the view its packet type selects
    typedef union packed {
        dataField_s data;
        ctrlField_s ctrl;
    } payload_u;

    typedef struct packed {
        pktType_e pktType;
        nodeId_t  src;
        nodeId_t  dst;
        payload_u payload;
    } packet_s;

    // Filter to cluster table
    typedef struct packed {
        logic       elect;
        logic       slot;
        logic       beat;
        logic       inv;
        nodeId_t    src;
        ctrlField_s fields;
    } ctrlEvent_s;

    typedef struct packed {
        logic       headValid;
        nodeId_t    headId;
        logic [7:0] rank;
        logic [7:0] slot;
    } status_s;

    typedef struct packed {
        logic                         isStatus;
        logic [$bits(packet_s)-1:0]   body;     // packet_s or zero padded status_s
    } hostRec_s;

    localparam int PADW = $bits(packet_s) - $bits(status_s);

endpackage

/* pktReceiver.sv */
`timescale 1ns/1ps

module pktReceiver (
    input  logic             clk,
    input  logic             nrst,
    input  logic             pktReq,
    input  nodePkg::packet_s pkt,
    output logic             pktAck,
    input  logic             spaceOk,
    output logic             newPkt,
    output nodePkg::packet_s rxPkt
);

    typedef enum logic {
        RX_IDLE,
        RX_ACK
    } rxState_e;

    rxState_e state;
    logic     accept;

    // Only take a packet when the queue has room for it
    assign accept = (state == RX_IDLE) && pktReq && spaceOk;
    assign pktAck = (state == RX_ACK);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state  <= RX_IDLE;
            newPkt <= 1'b0;
        end else begin
            newPkt <= accept;   // One cycle pulse
            case (state)
                RX_IDLE: begin
                    if (accept) begin
                        state <= RX_ACK;
                    end
                end
                RX_ACK: begin
                    // Wait for the sender to release
                    if (!pktReq) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rxPkt <= pkt;
        end
    end

    // Ack only ever answers a request seen on the previous edge
    assert property (@(posedge clk) disable iff (!nrst)
        $rose(pktAck) |-> $past(pktReq))
        else $error("pktReceiver raised pktAck without pktReq");

endmodule

/* packetFilter.sv */
`timescale 1ns/1ps

module packetFilter (
    input  logic               clk,
    input  logic               nrst,
    input  logic               newPkt,
    input  nodePkg::packet_s   rxPkt,
    input  nodePkg::nodeId_t   myNodeId,
    output logic               qWrite,
    output nodePkg::packet_s   qPkt,
    output nodePkg::ctrlEvent_s ctrl
);

    import nodePkg::*;

    logic forMe;

    assign forMe = (rxPkt.dst == myNodeId);

    always_ff @(posedge clk) begin
        qPkt        <= rxPkt;
        ctrl.src    <= rxPkt.src;
        ctrl.fields <= rxPkt.payload.ctrl;  // Rank and timeslot view
        if (!nrst) begin
            qWrite     <= 1'b0;
            ctrl.elect <= 1'b0;
            ctrl.slot  <= 1'b0;
            ctrl.beat  <= 1'b0;
            ctrl.inv   <= 1'b0;
        end else begin
            qWrite     <= 1'b0;
            ctrl.elect <= 1'b0;
            ctrl.slot  <= 1'b0;
            ctrl.beat  <= 1'b0;
            ctrl.inv   <= 1'b0;
            if (newPkt) begin
                case (rxPkt.pktType)
                    PT_MEMBER,
                    PT_DATA:      qWrite     <= forMe;
                    PT_SOS:       qWrite     <= 1'b1;     // Any destination
                    PT_ELECT:     ctrl.elect <= 1'b1;
                    PT_SLOT:      ctrl.slot  <= 1'b1;
                    PT_HEARTBEAT: ctrl.beat  <= 1'b1;
                    PT_INVALID:   ctrl.inv   <= 1'b1;
                    default:      qWrite     <= 1'b0;     // Type 111
                endcase
            end
        end
    end

    // Queue and cluster paths never fire for the same packet
    assert property (@(posedge clk) disable iff (!nrst)
        $onehot0({qWrite, ctrl.elect, ctrl.slot, ctrl.beat, ctrl.inv}))
        else $error("packetFilter raised more than one strobe");

endmodule

/* trafficQueue.sv */
`timescale 1ns/1ps

module trafficQueue (
    input  logic             clk,
    input  logic             nrst,
    input  logic             qWrite,
    input  nodePkg::packet_s qPkt,
    input  logic             qPop,
    output logic             qValid,
    output nodePkg::packet_s qHead,
    output logic             spaceOk
);

    import nodePkg::*;

    packet_s          mem [QDEPTH];
    logic [QPTRW-1:0] wrPtr;
    logic [QPTRW-1:0] rdPtr;
    logic [QPTRW:0]   count;
    logic             doWrite;
    logic             doPop;

    assign doWrite = qWrite && (count != QFULL);
    assign doPop   = qPop && qValid;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= qPkt;
        end
    end

    // Pointers wrap on their own as depth is a power of two
    always_ff @(posedge clk) begin
        if (!nrst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    assign qValid  = (count != '0);
    assign qHead   = mem[rdPtr];
    assign spaceOk = (count <= QLOW);

    // Receiver must have stopped acking before the queue filled
    assert property (@(posedge clk) disable iff (!nrst)
        qWrite |-> (count != QFULL))
        else $error("trafficQueue write while full");

    // Host side pops only what is there
    assert property (@(posedge clk) disable iff (!nrst)
        qPop |-> qValid)
        else $error("trafficQueue pop while empty");

endmodule

/* clusterTable.sv */
`timescale 1ns/1ps

module clusterTable (
    input  logic                clk,
    input  logic                nrst,
    input  nodePkg::ctrlEvent_s ctrl,
    output nodePkg::status_s    status,
    output logic                changed
);

    import nodePkg::*;

    status_s nextStatus;
    logic    fromHead;
    logic    betterHead;

    // An invalidated table has no head to match
    assign fromHead   = status.headValid && (ctrl.src == status.headId);
    assign betterHead = !status.headValid || (ctrl.fields.rank > status.rank);

    always_comb begin
        nextStatus = status;
        if (ctrl.elect && betterHead) begin
            nextStatus.headValid = 1'b1;
            nextStatus.headId    = ctrl.src;
            nextStatus.rank      = ctrl.fields.rank;   // Timeslot kept
        end
        if (ctrl.slot && fromHead) begin
            nextStatus.slot = ctrl.fields.slot;
        end
        if (ctrl.beat && fromHead) begin
            nextStatus.rank = ctrl.fields.rank;
        end
        if (ctrl.inv) begin
            nextStatus = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            status  <= '0;
            changed <= 1'b0;
        end else begin
            status  <= nextStatus;
            changed <= (nextStatus != status);  // Only on a real change
        end
    end

endmodule

/* hostPort.sv */
`timescale 1ns/1ps

module hostPort (
    input  logic              clk,
    input  logic              nrst,
    input  logic              qValid,
    input  nodePkg::packet_s  qHead,
    output logic              qPop,
    input  nodePkg::status_s  status,
    input  logic              changed,
    output logic              hostReq,
    input  logic              hostAck,
    output nodePkg::hostRec_s hostRec
);

    import nodePkg::*;

    typedef enum logic [1:0] {
        HP_IDLE,
        HP_REQ,
        HP_RELEASE
    } hpState_e;

    hpState_e state;
    logic     statusPending;
    logic     wantStatus;
    logic     loadStatus;

    // Reports win over queued packets
    assign wantStatus = statusPending || changed;
    assign loadStatus = (state == HP_IDLE) && wantStatus;
    assign qPop       = (state == HP_IDLE) && !wantStatus && qValid;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state   <= HP_IDLE;
            hostReq <= 1'b0;
        end else begin
            case (state)
                HP_IDLE: begin
                    if (loadStatus || qPop) begin
                        state   <= HP_REQ;
                        hostReq <= 1'b1;
                    end
                end
                HP_REQ: begin
                    if (hostAck) begin
                        state   <= HP_RELEASE;
                        hostReq <= 1'b0;
                    end
                end
                HP_RELEASE: begin
                    if (!hostAck) begin
                        state <= HP_IDLE;
                    end
                end
                default: state <= HP_IDLE;
            endcase
        end
    end

    // Set out of reset so the host sees the empty table first
    always_ff @(posedge clk) begin
        if (!nrst) begin
            statusPending <= 1'b1;
        end else if (loadStatus) begin
            statusPending <= 1'b0;  // Live status already includes any change
        end else if (changed) begin
            statusPending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (loadStatus) begin
            hostRec.isStatus <= 1'b1;
            hostRec.body     <= {{PADW{1'b0}}, status};
        end else if (qPop) begin
            hostRec.isStatus <= 1'b0;
            hostRec.body     <= qHead;
        end
    end

    assert property (@(posedge clk) disable iff (!nrst)
        (hostReq && $past(hostReq)) |-> (hostRec == $past(hostRec)))
        else $error("hostPort changed hostRec during a transfer");

endmodule

/* nodeFrontEnd.sv */
`timescale 1ns/1ps

module nodeFrontEnd (
    input  logic              clk,
    input  logic              nrst,
    input  nodePkg::nodeId_t  myNodeId,
    input  logic              pktReq,
    input  nodePkg::packet_s  pkt,
    output logic              pktAck,
    output logic              hostReq,
    input  logic              hostAck,
    output nodePkg::hostRec_s hostRec
);

    import nodePkg::*;

    packet_s    rxPkt;
    packet_s    qPkt;
    packet_s    qHead;
    ctrlEvent_s ctrl;
    status_s    status;
    logic       newPkt;
    logic       spaceOk;
    logic       qWrite;
    logic       qValid;
    logic       qPop;
    logic       changed;

    pktReceiver i_pktReceiver (
        .clk     (clk),
        .nrst    (nrst),
        .pktReq  (pktReq),
        .pkt     (pkt),
        .pktAck  (pktAck),
        .spaceOk (spaceOk),
        .newPkt  (newPkt),
        .rxPkt   (rxPkt)
    );

    packetFilter i_packetFilter (
        .clk      (clk),
        .nrst     (nrst),
        .newPkt   (newPkt),
        .rxPkt    (rxPkt),
        .myNodeId (myNodeId),
        .qWrite   (qWrite),
        .qPkt     (qPkt),
        .ctrl     (ctrl)
    );

    trafficQueue i_trafficQueue (
        .clk     (clk),
        .nrst    (nrst),
        .qWrite  (qWrite),
        .qPkt    (qPkt),
        .qPop    (qPop),
        .qValid  (qValid),
        .qHead   (qHead),
        .spaceOk (spaceOk)
    );

    clusterTable i_clusterTable (
        .clk     (clk),
        .nrst    (nrst),
        .ctrl    (ctrl),
        .status  (status),
        .changed (changed)
    );

    hostPort i_hostPort (
        .clk     (clk),
        .nrst    (nrst),
        .qValid  (qValid),
        .qHead   (qHead),
        .qPop    (qPop),
        .status  (status),
        .changed (changed),
        .hostReq (hostReq),
        .hostAck (hostAck),
        .hostRec (hostRec)
    );

endmodule

/* tb_nodeFrontEnd.sv */
`timescale 1ns/1ps

module tb_nodeFrontEnd;

    import nodePkg::*;

    localparam nodeId_t MY_ID = 16'h3A5C;

    logic     clk;
    logic     nrst;
    nodeId_t  myNodeId;
    logic     pktReq;
    packet_s  pkt;
    logic     pktAck;
    logic     hostReq;
    logic     hostAck;
    hostRec_s hostRec;

    logic        hold;            // Host stalls while set
    logic [31:0] rngState;
    status_s     model;
    packet_s     expQ [$];
    packet_s     expHead;
    int          pktExp = 0;
    int          pktGot = 0;
    int          statusExp = 1;   // Reset report
    int          statusGot = 0;
    int          pendingAtStatus = 0;
    int          errors = 0;
    int          errMark = 0;
    int          tests = 0;

    nodeFrontEnd i_nodeFrontEnd (
        .clk      (clk),
        .nrst     (nrst),
        .myNodeId (myNodeId),
        .pktReq   (pktReq),
        .pkt      (pkt),
        .pktAck   (pktAck),
        .hostReq  (hostReq),
        .hostAck  (hostAck),
        .hostRec  (hostRec)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic packet_s makePkt(input pktType_e t, input nodeId_t src,
                                        input nodeId_t dst, input logic [15:0] word);
        packet_s p;
        p.pktType = t;
        p.src     = src;
        p.dst     = dst;
        p.payload = word;   // {seq, value} or {rank, slot}
        return p;
    endfunction

    function automatic void pushExp(input packet_s p);
        expQ.push_back(p);
        expHead = expQ[0];
        pktExp++;
    endfunction

    // Expected host traffic and cluster state for one accepted packet
    function automatic void applyModel(input packet_s p);
        status_s prev;
        prev = model;
        case (p.pktType)
            PT_ELECT: begin
                if (!model.headValid || p.payload.ctrl.rank > model.rank) begin
                    model.headValid = 1'b1;
                    model.headId    = p.src;
                    model.rank      = p.payload.ctrl.rank;
                end
            end
            PT_SLOT: begin
                if (model.headValid && p.src == model.headId) model.slot = p.payload.ctrl.slot;
            end
            PT_HEARTBEAT: begin
                if (model.headValid && p.src == model.headId) model.rank = p.payload.ctrl.rank;
            end
            PT_INVALID:       model = '0;
            PT_MEMBER, PT_DATA: begin
                if (p.dst == myNodeId) pushExp(p);
            end
            PT_SOS:           pushExp(p);
            default:          ;
        endcase
        if (model != prev) statusExp++;
    endfunction

    // Host side responder
    initial begin
        hostAck = 1'b0;
        forever begin
            @(posedge clk);
            if (hostReq && !hostAck && !hold) begin
                #1;
                hostAck = 1'b1;
                if (hostRec.isStatus) begin
                    statusGot++;
                    pendingAtStatus = expQ.size();
                end else begin
                    pktGot++;
                    void'(expQ.pop_front());
                    if (expQ.size() != 0) expHead = expQ[0];
                end
            end else if (hostAck && !hostReq) begin
                #1;
                hostAck = 1'b0;
            end
        end
    end

    assert property (@(posedge clk) !nrst |=> (!pktAck && !hostReq))
        else begin
            errors++;
            $display("FAILED %0t pktAck expected 0 got %b, hostReq expected 0 got %b",
                     $time, pktAck, hostReq);
        end

    assert property (@(posedge clk) disable iff (!nrst)
        (hostReq && !hostAck && hostRec.isStatus) |-> (hostRec.body == {{PADW{1'b0}}, model}))
        else begin
            errors++;
            $display("FAILED %0t hostRec.body expected %h got %h",
                     $time, {{PADW{1'b0}}, model}, hostRec.body);
        end

    // Packet records arrive only when expected
    assert property (@(posedge clk) disable iff (!nrst)
        (hostReq && !hostAck && !hostRec.isStatus) |-> (pktExp > pktGot))
        else begin
            errors++;
            $display("Unexpected packet record offered to the host at %0t", $time);
        end

    // Packet records arrive in the order they were accepted
    assert property (@(posedge clk) disable iff (!nrst)
        (hostReq && !hostAck && !hostRec.isStatus && pktExp > pktGot)
            |-> (hostRec.body == expHead))
        else begin
            errors++;
            $display("FAILED %0t hostRec.body expected %h got %h", $time, expHead, hostRec.body);
        end

    task automatic raiseReq(input packet_s p);
        @(posedge clk);
        #1;
        pkt    = p;
        pktReq = 1'b1;
    endtask

    task automatic waitAck(input int limit, output bit acked);
        int n;
        n     = 0;
        acked = 1'b0;
        while (!acked && n < limit) begin
            @(posedge clk);
            #1;
            acked = pktAck;
            n++;
        end
    endtask

    task automatic dropReq();
        int n;
        n      = 0;
        pktReq = 1'b0;
        while (pktAck && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pktAck) begin
            errors++;
            $display("Timeout: pktAck stayed high after pktReq fell");
        end
    endtask

    task automatic sendPkt(input packet_s p);
        bit acked;
        raiseReq(p);
        waitAck(50, acked);
        if (acked) begin
            applyModel(p);
        end else begin
            errors++;
            $display("Timeout: packet of type %0d was never acknowledged", p.pktType);
        end
        dropReq();
    endtask

    // Quiet for ten cycles with every expected packet delivered
    task automatic drain();
        int n;
        int quiet;
        n     = 0;
        quiet = 0;
        while (quiet < 10 && n < 300) begin
            @(posedge clk);
            #1;
            n++;
            if (!hostReq && !hostAck && pktGot == pktExp) quiet++;
            else quiet = 0;
        end
        if (quiet < 10) begin
            errors++;
            $display("Timeout: host side did not deliver all packets and go idle");
        end
        assert (statusGot == statusExp)
            else begin
                errors++;
                $display("FAILED %0t statusGot expected %0d got %0d", $time, statusExp, statusGot);
            end
    endtask

    task automatic deliver(input packet_s p);
        sendPkt(p);
        drain();
    endtask

    task automatic endTest(input string name);
        tests++;
        $display("Test %-14s %s", name, (errors == errMark) ? "ok" : "had errors");
        errMark = errors;
    endtask

    initial begin
        bit          acked;
        int          accepted;
        logic [31:0] r;
        nrst     = 1'b0;
        pktReq   = 1'b0;
        pkt      = '0;
        hold     = 1'b0;
        myNodeId = MY_ID;
        rngState = 32'hd73af98a;
        model    = '0;
        expHead  = '0;
        repeat (16) @(posedge clk);
        #1;
        nrst = 1'b1;
        drain();
        endTest("reset");

        for (int i = 0; i < 24; i++) begin
            r = nextRand();
            deliver(makePkt(pktType_e'(r[2:0]), 16'(nextRand()),
                            r[3] ? MY_ID : r[31:16], 16'(nextRand())));
        end
        endTest("filtering");

        deliver(makePkt(PT_INVALID, 16'h0001, MY_ID, 16'h0000));
        deliver(makePkt(PT_ELECT, 16'h1111, MY_ID, 16'h4007));
        deliver(makePkt(PT_ELECT, 16'h2222, MY_ID, 16'h3009));  // Lower rank
        deliver(makePkt(PT_ELECT, 16'h2222, MY_ID, 16'h4009));  // Equal rank
        deliver(makePkt(PT_ELECT, 16'h3333, MY_ID, 16'h4102));
        endTest("election");

        deliver(makePkt(PT_SLOT, 16'h1111, MY_ID, 16'h0005));
        deliver(makePkt(PT_SLOT, 16'h3333, MY_ID, 16'h0006));
        deliver(makePkt(PT_HEARTBEAT, 16'h2222, MY_ID, 16'h7700));
        deliver(makePkt(PT_HEARTBEAT, 16'h3333, MY_ID, 16'h5000));
        deliver(makePkt(PT_INVALID, 16'h0042, MY_ID, 16'h0000));
        endTest("head-only");

        hold = 1'b1;
        sendPkt(makePkt(PT_DATA, 16'h0101, MY_ID, 16'h0111));
        sendPkt(makePkt(PT_DATA, 16'h0101, MY_ID, 16'h0222));
        sendPkt(makePkt(PT_ELECT, 16'h0A0A, MY_ID, 16'h1003));
        sendPkt(makePkt(PT_ELECT, 16'h0B0B, MY_ID, 16'h2004));
        statusExp--;    // Second change merges into the pending report
        hold = 1'b0;
        drain();
        assert (pendingAtStatus == 1)
            else begin
                errors++;
                $display("FAILED %0t pendingAtStatus expected 1 got %0d", $time, pendingAtStatus);
            end
        endTest("priority");

        hold     = 1'b1;
        accepted = 0;
        acked    = 1'b1;
        while (acked && accepted < 8) begin
            raiseReq(makePkt(PT_SOS, 16'h0C0C, 16'hFFFF, 16'(accepted)));
            waitAck(40, acked);
            if (acked) begin
                applyModel(pkt);
                dropReq();
                accepted++;
            end
        end
        assert (accepted == QDEPTH)
            else begin
                errors++;
                $display("FAILED %0t accepted expected %0d got %0d", $time, QDEPTH, accepted);
            end
        hold = 1'b0;
        waitAck(100, acked);
        if (acked) begin
            applyModel(pkt);
        end else begin
            errors++;
            $display("Timeout: held packet was not accepted after the host resumed");
        end
        dropReq();
        drain();
        endTest("back-pressure");

        $display("Tests %0d, errors %0d, packets %0d, status reports %0d",
                 tests, errors, pktGot, statusGot);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
nodePkg.sv
pktReceiver.sv
packetFilter.sv
trafficQueue.sv
clusterTable.sv
hostPort.sv
nodeFrontEnd.sv
tb_nodeFrontEnd.sv
